// ==== Bender.yml ====
package:
  name: hawk_init

sources:
  - hawk_pkg.sv
  - hawk_axi_wr_if.sv
  - hawk_ctrl_unit.sv
  - hawk_pgwr_mngr.sv
  - hawk_tbl_mem.sv
  - hawk_init_top.sv
  - target: test
    files:
      - tb_hawk_init.sv

// ==== all.f ====
hawk_pkg.sv
hawk_axi_wr_if.sv
hawk_ctrl_unit.sv
hawk_pgwr_mngr.sv
hawk_tbl_mem.sv
hawk_init_top.sv
tb_hawk_init.sv

// ==== hawk_axi_wr_if.sv ====
// single-beat write path, address and data each one pulse
// no ids, no bursts and no write response
`timescale 1ns/1ps

interface hawk_axi_wr_if;
	import hawk_pkg::*;

	addr_t addr;     // held until data beat done
	line_t data;
	strb_t strb;     // byte enables on data
	logic  awvalid;  // one cycle pulse
	logic  wvalid;   // one cycle pulse
	logic  awready;  // low while an address is pending
	logic  wready;   // high while an address is pending

	modport master (
		output addr,
		output data,
		output strb,
		output awvalid,
		output wvalid,
		input  awready,
		input  wready
	);

	modport slave (
		input  addr,
		input  data,
		input  strb,
		input  awvalid,
		input  wvalid,
		output awready,
		output wready
	);

endinterface

// ==== hawk_ctrl_unit.sv ====
// sequences att init then list init from one start pulse
// done is sticky so a new start needs a reset first
`timescale 1ns/1ps

module hawk_ctrl_unit (
	input  logic clk_i,
	input  logic rst_ni,
	input  logic start,           // pulse seen only in idle
	input  logic init_att_done,   // sticky from manager
	input  logic init_list_done,  // sticky from manager
	output logic init_att,
	output logic init_list,
	output logic busy,
	output logic done
);
	import hawk_pkg::*;

	ctrl_state_t state_q;
	ctrl_state_t state_d;

	always_comb begin
		state_d = state_q;
		case (state_q)
			CTRL_IDLE: begin
				if (start) state_d = CTRL_RUN_ATT;
			end
			CTRL_RUN_ATT: begin
				if (init_att_done) state_d = CTRL_RUN_LIST; // list after att only
			end
			CTRL_RUN_LIST: begin
				if (init_list_done) state_d = CTRL_DONE;
			end
			default: state_d = CTRL_DONE; // parked until reset
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) state_q <= CTRL_IDLE;
		else         state_q <= state_d;
	end

	// outputs straight from state
	assign init_att  = (state_q == CTRL_RUN_ATT);
	assign init_list = (state_q == CTRL_RUN_LIST);
	assign busy      = init_att || init_list;
	assign done      = (state_q == CTRL_DONE);

	a_phase_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
		!(init_att && init_list)) else $error("att and list init requested together");

endmodule

// ==== hawk_init_top.sv ====
// hawk table init top: control unit, page-write manager, table memory
// start once after reset, done marks the end, latency not fixed
`timescale 1ns/1ps

module hawk_init_top (
	input  logic                            clk_i,
	input  logic                            rst_ni,
	input  logic                            start,     // single cycle pulse
	input  logic [hawk_pkg::LINE_IDX_W-1:0] rd_line,
	output logic                            busy,
	output logic                            done,
	output logic                            att_done,  // manager sticky flags
	output logic                            list_done,
	output logic [hawk_pkg::LINE_BITS-1:0]  rd_data    // valid one cycle after rd_line
);

	logic init_att;
	logic init_list;

	hawk_axi_wr_if wr_if ();

	hawk_ctrl_unit u_ctrl (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.start          (start),
		.init_att_done  (att_done),
		.init_list_done (list_done),
		.init_att       (init_att),
		.init_list      (init_list),
		.busy           (busy),
		.done           (done)
	);

	hawk_pgwr_mngr u_mngr (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.init_att       (init_att),
		.init_list      (init_list),
		.wr             (wr_if.master),
		.init_att_done  (att_done),
		.init_list_done (list_done)
	);

	hawk_tbl_mem u_mem (
		.clk_i   (clk_i),
		.rst_ni  (rst_ni),
		.wr      (wr_if.slave),
		.rd_line (rd_line),
		.rd_data (rd_data)
	);

endmodule

// ==== hawk_pgwr_mngr.sv ====
// page-write manager for the att and list init modes only
// one write in flight of at least 4 cycles and no write response
// done flags stay set until reset
`timescale 1ns/1ps

module hawk_pgwr_mngr (
	input  logic          clk_i,
	input  logic          rst_ni,
	input  logic          init_att,
	input  logic          init_list,
	hawk_axi_wr_if.master wr,
	output logic          init_att_done,
	output logic          init_list_done
);
	import hawk_pkg::*;

	pgwr_state_t state_q;
	pgwr_state_t state_d;
	entry_id_t   cnt_q;          // att line or list entry id
	entry_id_t   cnt_d;
	logic        aw_q;
	logic        aw_d;
	logic        w_q;
	logic        w_d;
	logic        att_done_set;
	logic        list_done_set;
	addr_t       pkt_addr;
	line_t       pkt_data;
	strb_t       pkt_strb;
	addr_t       addr_q;
	line_t       data_q;
	strb_t       strb_q;

	// builds the write packet for att line n or list entry n
	function automatic void build_pkt(input logic list_phase, input entry_id_t n,
		output addr_t addr, output line_t data, output strb_t strb);
		logic [ATT_ENTRY_SIZE*BYTE_BITS-1:0]  att_entry;
		logic [LIST_ENTRY_SIZE*BYTE_BITS-1:0] lst_entry;
		entry_id_t                            idx;
		entry_id_t                            next_id;
		int unsigned                          slot;
		att_entry = {ATT_ZPD_W'(0), ppa_t'(0), 1'b0}; // zpd cnt, way, sts all clear
		idx       = n - 16'd1;                        // list ids start at 1
		slot      = idx % LIST_ENTRY_PER_BLK;
		next_id   = (n == LIST_ENTRY_CNT) ? '0 : n + 16'd1; // tail points to null
		lst_entry = {LIST_RSVD_W'(0), HAWK_PPA_START + ppa_t'(n), idx, next_id};
		if (!list_phase) begin
			addr = HAWK_ATT_START + (addr_t'(n) << BLK_OFS_W);
			data = {ATT_ENTRY_PER_BLK{att_entry}}; // whole line at once
			strb = '1;
		end else begin
			addr = HAWK_LIST_START + (addr_t'(idx / LIST_ENTRY_PER_BLK) << BLK_OFS_W);
			data = line_t'(lst_entry) << (slot * LIST_ENTRY_SIZE * BYTE_BITS);
			strb = strb_t'({LIST_ENTRY_SIZE{1'b1}}) << (slot * LIST_ENTRY_SIZE);
		end
	endfunction

	always_comb begin
		state_d       = state_q;
		cnt_d         = cnt_q;
		aw_d          = 1'b0; // valids are single pulses
		w_d           = 1'b0;
		att_done_set  = 1'b0;
		list_done_set = 1'b0;
		build_pkt(state_q == PG_INIT_LIST, cnt_q, pkt_addr, pkt_data, pkt_strb);
		case (state_q)
			PG_IDLE: begin
				if (init_att && !init_att_done) begin
					state_d = PG_INIT_ATT;
					cnt_d   = '0;    // att line 0
				end else if (init_list && !init_list_done) begin
					state_d = PG_INIT_LIST;
					cnt_d   = 16'd1; // first real entry
				end
			end
			PG_INIT_ATT: begin
				if (wr.awready) begin
					if (cnt_q < ATT_LINES) begin
						aw_d    = 1'b1;
						cnt_d   = cnt_q + 16'd1;
						state_d = PG_WAIT_ATT;
					end else begin
						att_done_set = 1'b1; // all att lines sent
						state_d      = PG_IDLE;
					end
				end
			end
			PG_WAIT_ATT: begin
				if (wr.wready) begin // payload already on the bus
					w_d     = 1'b1;
					state_d = PG_INIT_ATT;
				end
			end
			PG_INIT_LIST: begin
				if (wr.awready) begin
					if (cnt_q <= LIST_ENTRY_CNT) begin
						aw_d    = 1'b1;
						cnt_d   = cnt_q + 16'd1;
						state_d = PG_WAIT_LIST;
					end else begin
						list_done_set = 1'b1;
						state_d       = PG_IDLE;
					end
				end
			end
			PG_WAIT_LIST: begin
				if (wr.wready) begin
					w_d     = 1'b1;
					state_d = PG_INIT_LIST;
				end
			end
			default: state_d = PG_IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q        <= PG_IDLE;
			cnt_q          <= '0;
			aw_q           <= 1'b0;
			w_q            <= 1'b0;
			init_att_done  <= 1'b0;
			init_list_done <= 1'b0;
		end else begin
			state_q <= state_d;
			cnt_q   <= cnt_d;
			aw_q    <= aw_d;
			w_q     <= w_d;
			if (att_done_set)  init_att_done  <= 1'b1; // sticky
			if (list_done_set) init_list_done <= 1'b1;
		end
	end

	// packet latched with awvalid and held through the data beat
	always_ff @(posedge clk_i) begin
		if (aw_d) begin
			addr_q <= pkt_addr;
			data_q <= pkt_data;
			strb_q <= pkt_strb;
		end
	end

	assign wr.awvalid = aw_q;
	assign wr.wvalid  = w_q;
	assign wr.addr    = addr_q;
	assign wr.data    = data_q;
	assign wr.strb    = strb_q;

	a_no_aw_w_overlap: assert property (@(posedge clk_i) disable iff (!rst_ni)
		!(wr.awvalid && wr.wvalid)) else $error("awvalid and wvalid together");

	a_line_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
		wr.awvalid |-> (wr.addr[BLK_OFS_W-1:0] == '0)) else $error("unaligned write address");

endmodule

// ==== hawk_pkg.sv ====
// table geometry, addresses and types for the hawk init path
// sizes are fixed here; list tail next is 0 (null)
// entry ids start at 1, id 0 is reserved as null
package hawk_pkg;

	localparam int BLK_SIZE   = 64;                    // bytes per line
	localparam int BYTE_BITS  = 8;
	localparam int LINE_BITS  = BLK_SIZE * BYTE_BITS;  // 512
	localparam int BLK_OFS_W  = $clog2(BLK_SIZE);      // byte offset bits in a line
	localparam int TBL_LINES  = 8;                     // att lines + list lines
	localparam int LINE_IDX_W = $clog2(TBL_LINES);

	localparam int ENTRY_ID_W = 16;
	localparam int PPA_W      = 48;

	typedef logic [LINE_BITS-1:0]  line_t;
	typedef logic [BLK_SIZE-1:0]   strb_t;             // one bit per byte
	typedef logic [63:0]           addr_t;
	typedef logic [PPA_W-1:0]      ppa_t;
	typedef logic [ENTRY_ID_W-1:0] entry_id_t;         // 0 is null
	typedef logic [LINE_IDX_W-1:0] line_idx_t;

	// att table, 8 byte entries
	localparam int ATT_ENTRY_SIZE    = 8;
	localparam int ATT_ENTRY_PER_BLK = BLK_SIZE / ATT_ENTRY_SIZE;
	localparam int ATT_ENTRY_CNT     = 32;
	localparam int ATT_LINES         = ATT_ENTRY_CNT / ATT_ENTRY_PER_BLK; // 4
	localparam int ATT_ZPD_W         = ATT_ENTRY_SIZE * BYTE_BITS - PPA_W - 1; // zpd cnt

	// list table, 16 byte entries {rsvd, way, prev, next}
	localparam int LIST_ENTRY_SIZE    = 16;
	localparam int LIST_ENTRY_PER_BLK = BLK_SIZE / LIST_ENTRY_SIZE;
	localparam int LIST_ENTRY_CNT     = 16;
	localparam int LIST_RSVD_W        = LIST_ENTRY_SIZE * BYTE_BITS - 2 * ENTRY_ID_W - PPA_W;

	localparam logic [7:0] FILL_BYTE = 8'hff;          // memory content after reset

	localparam addr_t HAWK_ATT_START  = 64'd0;
	localparam addr_t HAWK_LIST_START = 64'd256;       // memory line 4
	localparam ppa_t  HAWK_PPA_START  = 48'h100;

	typedef enum logic [1:0] {
		CTRL_IDLE,
		CTRL_RUN_ATT,
		CTRL_RUN_LIST,
		CTRL_DONE
	} ctrl_state_t;

	typedef enum logic [2:0] {
		PG_IDLE,
		PG_INIT_ATT,
		PG_WAIT_ATT,
		PG_INIT_LIST,
		PG_WAIT_LIST
	} pgwr_state_t;

endpackage

// ==== hawk_tbl_mem.sv ====
// strobed line memory, write slave for one pending address
// every byte is FILL_BYTE after reset, readback one cycle late
// address bits above the table size are not decoded
`timescale 1ns/1ps

module hawk_tbl_mem (
	input  logic                clk_i,
	input  logic                rst_ni,
	hawk_axi_wr_if.slave        wr,
	input  hawk_pkg::line_idx_t rd_line,
	output hawk_pkg::line_t     rd_data
);
	import hawk_pkg::*;

	line_t     mem_q [TBL_LINES];
	logic      pending_q;   // address taken, data beat outstanding
	line_idx_t wr_line_q;
	logic      aw_take;
	logic      w_take;

	assign aw_take    = wr.awvalid && !pending_q;
	assign w_take     = wr.wvalid && pending_q;
	assign wr.awready = !pending_q;
	assign wr.wready  = pending_q;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni)      pending_q <= 1'b0;
		else if (aw_take) pending_q <= 1'b1;
		else if (w_take)  pending_q <= 1'b0; // ready for next address
	end

	always_ff @(posedge clk_i) begin
		if (aw_take) wr_line_q <= wr.addr[BLK_OFS_W +: LINE_IDX_W]; // line index bits 8..6
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			for (int i = 0; i < TBL_LINES; i++) begin
				mem_q[i] <= {BLK_SIZE{FILL_BYTE}};
			end
		end else if (w_take) begin
			for (int b = 0; b < BLK_SIZE; b++) begin
				if (wr.strb[b]) begin // only enabled bytes change
					mem_q[wr_line_q][b*BYTE_BITS +: BYTE_BITS] <= wr.data[b*BYTE_BITS +: BYTE_BITS];
				end
			end
		end
	end

	// registered readback
	always_ff @(posedge clk_i) begin
		rd_data <= mem_q[rd_line];
	end

	a_w_needs_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
		wr.wvalid |-> pending_q) else $error("data beat without pending address");

	a_addr_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
		aw_take |-> (wr.addr < addr_t'(TBL_LINES * BLK_SIZE)))
		else $error("write address beyond table memory");

endmodule

// ==== tb_hawk_init.sv ====
// testbench for hawk_init_top, random idle gaps, start pulses and readback order
// expected tables are built from the entry layout, fixed seed for all runs
`timescale 1ns/1ps

module tb_hawk_init;
	import hawk_pkg::*;

	logic      clk_i;
	logic      rst_ni;
	logic      start;
	line_idx_t rd_line;
	logic      busy;
	logic      done;
	logic      att_done;
	logic      list_done;
	line_t     rd_data;

	line_t model [TBL_LINES];  // expected memory content
	int    errors;
	int    test_errs;          // error count at start of current test
	int    n_tests;
	int    seed_dummy;
	line_t got;

	hawk_init_top u_hawk_init_top (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.start     (start),
		.rd_line   (rd_line),
		.busy      (busy),
		.done      (done),
		.att_done  (att_done),
		.list_done (list_done),
		.rd_data   (rd_data)
	);

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i; // 4 ns period
	end

	task automatic check_val(input string name, input line_t exp, input line_t act);
		if (exp !== act) begin
			$display("CHECK FAILED %s expected %0h actual %0h", name, exp, act);
			errors++;
		end
	endtask

	// flags packed as {busy, done, att_done, list_done}
	task automatic flags_are(input string name, input logic [3:0] exp);
		check_val(name, line_t'(exp), line_t'({busy, done, att_done, list_done}));
	endtask

	task automatic end_test(input string name);
		n_tests++;
		$display("test %s finished, %0d error(s)", name, errors - test_errs);
		test_errs = errors;
	endtask

	// poll one status output on falling edges, bounded
	task automatic wait_high(input int sel, input string what, input int limit);
		int   n;
		logic v;
		n = 0;
		v = 1'b0;
		while (!v && n < limit) begin
			@(negedge clk_i);
			case (sel)
				0:       v = busy;
				1:       v = att_done;
				2:       v = list_done;
				default: v = done;
			endcase
			n++;
		end
		if (!v) begin
			$display("timeout: %s did not rise within %0d cycles", what, limit);
			errors++;
		end
	endtask

	task automatic pulse_start();
		@(negedge clk_i);
		start = 1'b1;
		@(negedge clk_i);
		start = 1'b0;
	endtask

	task automatic read_line(input int idx, output line_t data);
		@(negedge clk_i);
		rd_line = line_idx_t'(idx);
		@(negedge clk_i); // registered port, one cycle
		data = rd_data;
	endtask

	// reads count lines from first on, shuffled
	task automatic check_lines(input string name, input int first, input int count);
		int    order [TBL_LINES];
		int    j;
		int    t;
		line_t rd;
		for (int i = 0; i < count; i++) order[i] = first + i;
		for (int i = count - 1; i > 0; i--) begin
			j        = $urandom_range(i, 0);
			t        = order[i];
			order[i] = order[j];
			order[j] = t;
		end
		for (int i = 0; i < count; i++) begin
			read_line(order[i], rd);
			check_val($sformatf("%s line %0d", name, order[i]), model[order[i]], rd);
		end
	endtask

	function automatic void fill_model();
		for (int i = 0; i < TBL_LINES; i++) model[i] = {BLK_SIZE{8'hff}};
	endfunction

	// att lines cleared, list ids 1..16 linked, tail next is null
	function automatic void set_expected();
		logic [127:0] ent;
		int           ln;
		for (int i = 0; i < 4; i++) model[i] = '0;
		for (int e = 1; e <= 16; e++) begin
			ent        = '0;                               // reserved stays zero
			ent[15:0]  = (e == 16) ? 16'd0 : 16'(e + 1);   // next
			ent[31:16] = 16'(e - 1);                       // prev
			ent[79:32] = 48'h100 + 48'(e);                 // way
			ln         = 256 / 64 + (e - 1) / 4;
			model[ln][((e - 1) % 4) * 128 +: 128] = ent;
		end
	endfunction

	// full run with phase order checks
	task automatic run_init(input string name);
		pulse_start();
		wait_high(0, "busy", 20);
		wait_high(1, "att_done", 500);
		flags_are({name, " att phase end"}, 4'b1010); // list not yet done
		wait_high(2, "list_done", 1000);
		flags_are({name, " list phase end"}, 4'b1011); // done one edge later
		wait_high(3, "done", 20);
		flags_are({name, " finished"}, 4'b0111);
	endtask

	initial begin
		seed_dummy = $urandom(32'hec85ccf4);
		errors     = 0;
		test_errs  = 0;
		n_tests    = 0;
		rst_ni     = 1'b0;
		start      = 1'b0;
		rd_line    = '0;
		fill_model();
		repeat (5) @(negedge clk_i);
		rst_ni = 1'b1;

		repeat ($urandom_range(8, 1)) @(negedge clk_i); // idle gap
		flags_are("after_reset flags", 4'b0000);
		for (int i = 0; i < 4; i++) begin
			seed_dummy = $urandom_range(TBL_LINES - 1, 0);
			read_line(seed_dummy, got);
			check_val($sformatf("after_reset line %0d", seed_dummy), model[seed_dummy], got);
		end
		end_test("after_reset");

		run_init("phase_order");
		end_test("phase_order");
		set_expected();
		check_lines("att_lines", 0, 4);
		end_test("att_lines");
		check_lines("list_lines", 4, 4);
		end_test("list_lines");

		repeat ($urandom_range(6, 2)) begin
			repeat ($urandom_range(5, 1)) @(negedge clk_i);
			pulse_start();
			@(negedge clk_i);
			flags_are("restart_ignored flags", 4'b0111);
		end
		check_lines("restart_ignored", 0, TBL_LINES);
		end_test("restart_ignored");

		// second run, cut short by a reset
		rst_ni = 1'b0;
		repeat (5) @(negedge clk_i);
		rst_ni = 1'b1;
		pulse_start();
		repeat ($urandom_range(60, 1)) @(negedge clk_i);
		rst_ni = 1'b0;
		repeat (5) @(negedge clk_i);
		rst_ni = 1'b1;
		@(negedge clk_i);
		flags_are("reset_clears flags", 4'b0000);
		fill_model();
		check_lines("reset_clears fill", 0, TBL_LINES);
		run_init("rerun");
		set_expected();
		check_lines("rerun tables", 0, TBL_LINES);
		end_test("reset_clears");

		$display("%0d tests run, %0d errors", n_tests, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule
